/* compile.f */
hdl/mine_pkg.sv
hdl/neighbor_counter.sv
hdl/board_ctrl.sv
hdl/color_matrix.sv
hdl/cell_palette.sv
hdl/minesweeper_top.sv
test/minesweeper_checker.sv
test/tb_minesweeper.sv

/* hdl/board_ctrl.sv */
`timescale 1ns/1ps

module board_ctrl
  import mine_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           cmd_valid,   // one command per cycle, no stall
  input  cmd_t                           cmd,
  input  logic [board_dim*board_dim-1:0] mine_map,    // sampled on CMD_LOAD only
  input  logic [3:0]                     counts [0:board_dim-1][0:board_dim-1],
  output logic [board_dim*board_dim-1:0] mines,       // stored map, feeds the counter
  output logic [cell_bits-1:0]           board  [0:board_dim-1][0:board_dim-1],
  output game_t                          game_state,
  output logic [2:0]                     cursor_row,
  output logic [2:0]                     cursor_col
);

  logic [board_dim*board_dim-1:0] mine_q;      // loaded mine map
  logic [board_dim*board_dim-1:0] revealed_q;  // opened cells
  logic [board_dim*board_dim-1:0] flag_q;      // flagged cells
  logic [6:0]                     revealed_cnt; // opened safe cells so far
  logic [6:0]                     safe_cnt;    // non-mine cells in current map
  logic [5:0]                     cur_idx;     // cursor as flat index
  logic                           playing;
  logic                           cur_mine;
  logic                           cur_open;
  logic                           cur_flag;

  assign cur_idx  = {cursor_row, cursor_col};  // row*8 + col
  assign playing  = (game_state == GAME_PLAY);
  assign cur_mine = mine_q[cur_idx];
  assign cur_open = revealed_q[cur_idx];
  assign cur_flag = flag_q[cur_idx];
  assign mines    = mine_q;

  // command decode, every valid command lands on this edge
  always_ff @(posedge clk) begin
    if (rst) begin
      mine_q       <= '0;
      revealed_q   <= '0;
      flag_q       <= '0;
      revealed_cnt <= '0;
      safe_cnt     <= '0;
      cursor_row   <= '0;
      cursor_col   <= '0;
      game_state   <= GAME_IDLE;
    end else if (cmd_valid) begin
      case (cmd)
        CMD_LOAD: begin                        // allowed in any state
          mine_q       <= mine_map;
          revealed_q   <= '0;
          flag_q       <= '0;
          revealed_cnt <= '0;
          safe_cnt     <= 7'(board_dim*board_dim) - 7'($countones(mine_map));
          cursor_row   <= '0;
          cursor_col   <= '0;
          game_state   <= GAME_PLAY;
        end
        CMD_UP: begin
          if (playing) cursor_row <= cursor_row - 3'd1;  // 3-bit wrap
        end
        CMD_DOWN: begin
          if (playing) cursor_row <= cursor_row + 3'd1;
        end
        CMD_LEFT: begin
          if (playing) cursor_col <= cursor_col - 3'd1;
        end
        CMD_RIGHT: begin
          if (playing) cursor_col <= cursor_col + 3'd1;
        end
        CMD_REVEAL: begin
          if (playing && !cur_flag && !cur_open) begin
            revealed_q[cur_idx] <= 1'b1;
            if (cur_mine) begin
              game_state <= GAME_LOST;
            end else begin
              revealed_cnt <= revealed_cnt + 7'd1;
              // last safe cell opened wins
              if (revealed_cnt + 7'd1 == safe_cnt) game_state <= GAME_WON;
            end
          end
        end
        CMD_FLAG: begin
          if (playing && !cur_open) flag_q[cur_idx] <= ~cur_flag;  // toggle
        end
        default: begin
        end
      endcase
    end
  end

  // cell word assembly, straight from registers
  always_comb begin
    int idx;
    idx = 0;
    for (int r = 0; r < board_dim; r++) begin
      for (int c = 0; c < board_dim; c++) begin
        idx = r*board_dim + c;
        if (game_state == GAME_LOST && mine_q[idx]) begin
          board[r][c] = '1;                    // exploded marking
        end else begin
          board[r][c]               = '0;
          board[r][c][bit_flag]     = flag_q[idx];
          board[r][c][bit_revealed] = revealed_q[idx];
          board[r][c][bit_cursor]   = (3'(r) == cursor_row) && (3'(c) == cursor_col);
          if (revealed_q[idx]) board[r][c][3:0] = counts[r][c];
        end
      end
    end
  end

endmodule

/* hdl/cell_palette.sv */
`timescale 1ns/1ps

module cell_palette
  import mine_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic [code_bits-1:0] board_colors [0:board_dim-1][0:board_dim-1],
  input  logic                 rd_en,
  input  logic [2:0]           rd_row,
  input  logic [2:0]           rd_col,
  output logic                 rd_valid,   // rd_en delayed one cycle
  output logic [code_bits-1:0] rd_code,
  output logic [23:0]          rd_rgb
);

  logic [code_bits-1:0] sel_code;          // addressed cell, before the register
  logic [23:0]          sel_rgb;

  assign sel_code = board_colors[rd_row][rd_col];

  // palette lookup
  always_comb begin
    case (sel_code)
      4'h0:    sel_rgb = rgb_code_0;
      4'h1:    sel_rgb = rgb_code_1;
      4'h2:    sel_rgb = rgb_code_2;
      4'h3:    sel_rgb = rgb_code_3;
      4'h4:    sel_rgb = rgb_code_4;
      4'h5:    sel_rgb = rgb_code_5;
      4'h6:    sel_rgb = rgb_code_6;
      4'h7:    sel_rgb = rgb_code_7;
      4'h8:    sel_rgb = rgb_code_8;
      4'h9:    sel_rgb = rgb_code_9;
      4'hA:    sel_rgb = rgb_code_10;
      4'hB:    sel_rgb = rgb_code_11;
      4'hC:    sel_rgb = rgb_code_12;
      default: sel_rgb = 24'h000000;       // black for anything unknown
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) rd_valid <= 1'b0;
    else     rd_valid <= rd_en;
  end

  // data regs only load on a request
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_code <= sel_code;
      rd_rgb  <= sel_rgb;
    end
  end

endmodule

/* hdl/color_matrix.sv */
`timescale 1ns/1ps

module color_matrix
  import mine_pkg::*;
(
  input  logic [cell_bits-1:0] board        [0:board_dim-1][0:board_dim-1],
  output logic [code_bits-1:0] board_colors [0:board_dim-1][0:board_dim-1]
);

  // per-cell precedence: exploded, flag, cursor, count, hidden
  always_comb begin
    logic [cell_bits-1:0] w;
    w = '0;
    for (int r = 0; r < board_dim; r++) begin
      for (int c = 0; c < board_dim; c++) begin
        w = board[r][c];
        if (&w) begin
          board_colors[r][c] = code_mine_lost;
        end else if (w[bit_flag]) begin
          board_colors[r][c] = code_flag;      // flag outranks cursor
        end else if (w[bit_cursor]) begin
          board_colors[r][c] = code_cursor;
        end else if (w[bit_revealed]) begin
          case (w[3:0])
            4'd0:    board_colors[r][c] = code_count_0;
            4'd1:    board_colors[r][c] = code_count_1;
            4'd2:    board_colors[r][c] = code_count_2;
            4'd3:    board_colors[r][c] = code_count_3;
            4'd4:    board_colors[r][c] = code_count_4;
            4'd5:    board_colors[r][c] = code_count_5;
            4'd6:    board_colors[r][c] = code_count_6;
            4'd7:    board_colors[r][c] = code_count_7;
            default: board_colors[r][c] = code_hidden;  // count 8 lands on 8 too
          endcase
        end else begin
          board_colors[r][c] = code_hidden;
        end
      end
    end
  end

endmodule

/* hdl/mine_pkg.sv */
package mine_pkg;

  localparam int board_dim = 8;   // cells per side
  localparam int cell_bits = 9;   // cell word width
  localparam int code_bits = 4;   // color code width

  // cell word layout, bits 3:0 carry the neighbor count
  localparam int bit_flag     = 8;
  localparam int bit_revealed = 7;
  localparam int bit_cursor   = 4;

  // color codes seen by the display side
  localparam logic [3:0] code_count_0   = 4'h0;
  localparam logic [3:0] code_count_1   = 4'h1;
  localparam logic [3:0] code_count_2   = 4'h2;
  localparam logic [3:0] code_count_3   = 4'h3;
  localparam logic [3:0] code_count_4   = 4'h4;
  localparam logic [3:0] code_count_5   = 4'h5;
  localparam logic [3:0] code_count_6   = 4'h6;
  localparam logic [3:0] code_count_7   = 4'h7;
  localparam logic [3:0] code_hidden    = 4'h8;
  localparam logic [3:0] code_flag      = 4'h9;
  localparam logic [3:0] code_cursor    = 4'hA;
  localparam logic [3:0] code_mine_lost = 4'hC;

  typedef enum logic [2:0] {
    CMD_NOP    = 3'd0,
    CMD_LOAD   = 3'd1,
    CMD_UP     = 3'd2,   // row - 1
    CMD_DOWN   = 3'd3,   // row + 1
    CMD_LEFT   = 3'd4,   // col - 1
    CMD_RIGHT  = 3'd5,   // col + 1
    CMD_REVEAL = 3'd6,
    CMD_FLAG   = 3'd7
  } cmd_t;

  typedef enum logic [1:0] {
    GAME_IDLE = 2'd0,
    GAME_PLAY = 2'd1,
    GAME_LOST = 2'd2,
    GAME_WON  = 2'd3
  } game_t;

  // palette, one entry per color code
  localparam logic [23:0] rgb_code_0  = 24'h7673D6;  // blue grey
  localparam logic [23:0] rgb_code_1  = 24'h73B5D6;  // light blue grey
  localparam logic [23:0] rgb_code_2  = 24'h73D6A2;  // green grey
  localparam logic [23:0] rgb_code_3  = 24'h76D673;  // yellow green grey
  localparam logic [23:0] rgb_code_4  = 24'hBED673;  // yellow grey
  localparam logic [23:0] rgb_code_5  = 24'hD6CA73;  // yellow orange grey
  localparam logic [23:0] rgb_code_6  = 24'hD69B73;  // orange grey
  localparam logic [23:0] rgb_code_7  = 24'hD67373;  // red grey
  localparam logic [23:0] rgb_code_8  = 24'hB1B1B1;  // hidden cell
  localparam logic [23:0] rgb_code_9  = 24'h818181;  // flagged cell
  localparam logic [23:0] rgb_code_10 = 24'hE8E8E8;  // cursor
  localparam logic [23:0] rgb_code_11 = 24'h793960;  // violet, no producer yet
  localparam logic [23:0] rgb_code_12 = 24'h660000;  // exploded mine

endpackage

/* hdl/minesweeper_top.sv */
`timescale 1ns/1ps

module minesweeper_top
  import mine_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           cmd_valid,
  input  cmd_t                           cmd,
  input  logic [board_dim*board_dim-1:0] mine_map,
  input  logic                           rd_en,
  input  logic [2:0]                     rd_row,
  input  logic [2:0]                     rd_col,
  output game_t                          game_state,
  output logic [2:0]                     cursor_row,
  output logic [2:0]                     cursor_col,
  output logic                           rd_valid,
  output logic [code_bits-1:0]           rd_code,
  output logic [23:0]                    rd_rgb
);

  logic [board_dim*board_dim-1:0] mines;   // registered map from the controller
  logic [3:0]                     counts       [0:board_dim-1][0:board_dim-1];
  logic [cell_bits-1:0]           board        [0:board_dim-1][0:board_dim-1];
  logic [code_bits-1:0]           board_colors [0:board_dim-1][0:board_dim-1];

  board_ctrl board_ctrl_i (
    .clk        (clk),
    .rst        (rst),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .mine_map   (mine_map),
    .counts     (counts),
    .mines      (mines),
    .board      (board),
    .game_state (game_state),
    .cursor_row (cursor_row),
    .cursor_col (cursor_col)
  );

  neighbor_counter neighbor_counter_i (
    .mine_map (mines),
    .counts   (counts)
  );

  color_matrix color_matrix_i (
    .board        (board),
    .board_colors (board_colors)
  );

  cell_palette cell_palette_i (
    .clk          (clk),
    .rst          (rst),
    .board_colors (board_colors),
    .rd_en        (rd_en),
    .rd_row       (rd_row),
    .rd_col       (rd_col),
    .rd_valid     (rd_valid),
    .rd_code      (rd_code),
    .rd_rgb       (rd_rgb)
  );

endmodule

/* hdl/neighbor_counter.sv */
`timescale 1ns/1ps

module neighbor_counter
  import mine_pkg::*;
(
  input  logic [board_dim*board_dim-1:0] mine_map,                         // bit r*8+c
  output logic [3:0]                     counts [0:board_dim-1][0:board_dim-1]
);

  // plain adder tree per cell, eight 1-bit inputs at most
  always_comb begin
    logic [3:0] sum;
    int         rr;
    int         cc;
    sum = '0;
    rr  = 0;
    cc  = 0;
    for (int r = 0; r < board_dim; r++) begin
      for (int c = 0; c < board_dim; c++) begin
        sum = '0;
        for (int dr = -1; dr <= 1; dr++) begin
          for (int dc = -1; dc <= 1; dc++) begin
            rr = r + dr;
            cc = c + dc;
            // skip the cell itself and anything off the board
            if ((dr != 0 || dc != 0) &&
                rr >= 0 && rr < board_dim &&
                cc >= 0 && cc < board_dim) begin
              sum = sum + 4'(mine_map[rr*board_dim + cc]);
            end
          end
        end
        counts[r][c] = sum;                  // 0..8
      end
    end
  end

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_minesweeper -o sim_minesweeper
./obj_dir/sim_minesweeper > sim.log 2>&1
cat sim.log

if grep -q "Finished with errors" sim.log; then
  exit 1
fi

/* test/minesweeper_checker.sv */
`timescale 1ns/1ps

module minesweeper_checker
  import mine_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 rd_en,       // request seen by the DUT
  input  logic [2:0]           rd_row,
  input  logic [2:0]           rd_col,
  input  logic                 rd_valid,
  input  logic [code_bits-1:0] rd_code,
  input  logic [23:0]          rd_rgb,
  input  game_t                game_state,
  input  logic [2:0]           cursor_row,
  input  logic [2:0]           cursor_col,
  input  logic [code_bits-1:0] exp_code,    // expectation for the request on rd_en
  input  logic [23:0]          exp_rgb,
  input  game_t                exp_state,
  input  logic [2:0]           exp_row,     // cursor expected while the request is served
  input  logic [2:0]           exp_col,
  input  int                   test_id,
  input  logic                 test_done,   // one-cycle pulse at the end of a test
  input  logic                 all_done,
  output int                   error_count
);

  logic                 req_q;              // read sampled at the last rising edge
  logic                 done_q;
  logic                 all_q;
  logic [code_bits-1:0] exp_code_q;
  logic [23:0]          exp_rgb_q;
  game_t                exp_state_q;
  logic [2:0]           exp_row_q;
  logic [2:0]           exp_col_q;
  logic [2:0]           row_q;
  logic [2:0]           col_q;
  int                   test_q;
  int                   test_checks  = 0;
  int                   test_errors  = 0;
  int                   total_checks = 0;
  int                   errors_total = 0;
  int                   tests_run    = 0;

  assign error_count = errors_total;

  function automatic string test_name(input int id);
    case (id)
      0:       return "reset_state";
      1:       return "neighbor_counts";
      2:       return "cursor_and_flags";
      3:       return "game_lost";
      4:       return "game_won";
      5:       return "read_latency";
      default: return "unknown";
    endcase
  endfunction

  // capture the request together with what it should return
  always @(posedge clk) begin
    if (rst) begin
      req_q  <= 1'b0;
      done_q <= 1'b0;
      all_q  <= 1'b0;
    end else begin
      req_q  <= rd_en;
      done_q <= test_done;
      all_q  <= all_done;
    end
    exp_code_q  <= exp_code;
    exp_rgb_q   <= exp_rgb;
    exp_state_q <= exp_state;
    exp_row_q   <= exp_row;
    exp_col_q   <= exp_col;
    row_q       <= rd_row;
    col_q       <= rd_col;
    test_q      <= test_id;
  end

  // responses are settled by the falling edge
  always @(negedge clk) begin
    if (req_q) begin
      test_checks++;
      total_checks++;
      if (rd_valid !== 1'b1) begin
        $display("%s: no read response one cycle after the request for cell %0d,%0d",
                 test_name(test_q), row_q, col_q);
        test_errors++;
        errors_total++;
      end else begin
        if (rd_code !== exp_code_q) begin
          $display("MISMATCH %s cell %0d,%0d code expected %h actual %h",
                   test_name(test_q), row_q, col_q, exp_code_q, rd_code);
          test_errors++;
          errors_total++;
        end
        if (rd_rgb !== exp_rgb_q) begin
          $display("MISMATCH %s cell %0d,%0d rgb expected %h actual %h",
                   test_name(test_q), row_q, col_q, exp_rgb_q, rd_rgb);
          test_errors++;
          errors_total++;
        end
        if (game_state !== exp_state_q) begin  // state is steady during a sweep
          $display("MISMATCH %s game_state expected %s actual %s",
                   test_name(test_q), exp_state_q.name(), game_state.name());
          test_errors++;
          errors_total++;
        end
        if (cursor_row !== exp_row_q || cursor_col !== exp_col_q) begin
          $display("MISMATCH %s cursor expected %0d,%0d actual %0d,%0d",
                   test_name(test_q), exp_row_q, exp_col_q, cursor_row, cursor_col);
          test_errors++;
          errors_total++;
        end
      end
    end else if (!rst && rd_valid !== 1'b0) begin
      $display("%s: read response appeared without a request", test_name(test_q));
      test_errors++;
      errors_total++;
    end
    if (done_q) begin
      $display("test %0d %s: %0d reads checked, %0d errors",
               test_q, test_name(test_q), test_checks, test_errors);
      tests_run++;
      test_checks = 0;
      test_errors = 0;
    end
    if (all_q) begin
      $display("%0d tests, %0d reads checked, %0d errors", tests_run, total_checks, errors_total);
    end
  end

endmodule

/* test/tb_minesweeper.sv */
`timescale 1ns/1ps

module tb_minesweeper
  import mine_pkg::*;
();

  localparam int cycles_per_cmd = 66;                     // one command plus 64 reads and an idle
  localparam int planned_cmds   = 1 + 128 + 14 + 5 + 128 + 2;
  localparam int cycle_limit    = planned_cmds * cycles_per_cmd * 12 / 10;

  logic                 clk;
  logic                 rst;
  logic                 cmd_valid;
  cmd_t                 cmd;
  logic [63:0]          mine_map;
  logic                 rd_en;
  logic [2:0]           rd_row;
  logic [2:0]           rd_col;
  game_t                game_state;
  logic [2:0]           cursor_row;
  logic [2:0]           cursor_col;
  logic                 rd_valid;
  logic [code_bits-1:0] rd_code;
  logic [23:0]          rd_rgb;
  logic [code_bits-1:0] exp_code;                         // goes with the current request
  logic [23:0]          exp_rgb;
  game_t                exp_state;
  logic [2:0]           exp_row;
  logic [2:0]           exp_col;
  int                   test_id;
  logic                 test_done;
  logic                 all_done;
  int                   error_count;
  logic [63:0]          mine_m;                           // shadow of the game
  logic [63:0]          rev_m;
  logic [63:0]          flag_m;
  logic [2:0]           cur_r;
  logic [2:0]           cur_c;
  game_t                state_m;
  logic [31:0]          lfsr_state;
  int                   cycle_cnt = 0;

  minesweeper_top minesweeper_i (
    .clk        (clk),
    .rst        (rst),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .mine_map   (mine_map),
    .rd_en      (rd_en),
    .rd_row     (rd_row),
    .rd_col     (rd_col),
    .game_state (game_state),
    .cursor_row (cursor_row),
    .cursor_col (cursor_col),
    .rd_valid   (rd_valid),
    .rd_code    (rd_code),
    .rd_rgb     (rd_rgb)
  );

  minesweeper_checker checker_i (
    .clk         (clk),
    .rst         (rst),
    .rd_en       (rd_en),
    .rd_row      (rd_row),
    .rd_col      (rd_col),
    .rd_valid    (rd_valid),
    .rd_code     (rd_code),
    .rd_rgb      (rd_rgb),
    .game_state  (game_state),
    .cursor_row  (cursor_row),
    .cursor_col  (cursor_col),
    .exp_code    (exp_code),
    .exp_rgb     (exp_rgb),
    .exp_state   (exp_state),
    .exp_row     (exp_row),
    .exp_col     (exp_col),
    .test_id     (test_id),
    .test_done   (test_done),
    .all_done    (all_done),
    .error_count (error_count)
  );

  always #50 clk = ~clk;                                  // 100 ns period

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: the run did not end within %0d cycles", cycle_limit);
      $display("Finished with errors");
      $finish;
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[62:0], lfsr_state[31]};
    end
  endtask

  task automatic random_map(output logic [63:0] m);
    logic [63:0] b;
    m = '0;
    for (int i = 0; i < 64; i++) begin
      rand_bits(2, b);
      m[i] = b[0] & b[1];                                 // roughly one mine in four
    end
  endtask

  // code and rgb of one cell taken from the shadow game
  function automatic logic [27:0] expected_cell(input int r, input int c);
    int          cnt;
    int          rr;
    int          cc;
    int          idx;
    logic [3:0]  code;
    logic [23:0] rgb;
    cnt = 0;
    idx = r * 8 + c;
    for (int dr = -1; dr <= 1; dr++) begin
      for (int dc = -1; dc <= 1; dc++) begin
        rr = r + dr;
        cc = c + dc;
        if ((dr != 0 || dc != 0) && rr >= 0 && rr < 8 && cc >= 0 && cc < 8 &&
            mine_m[rr * 8 + cc]) cnt++;
      end
    end
    if (state_m == GAME_LOST && mine_m[idx]) code = code_mine_lost;
    else if (flag_m[idx])                        code = code_flag;
    else if (3'(r) == cur_r && 3'(c) == cur_c)   code = code_cursor;
    else if (rev_m[idx])                         code = 4'(cnt);
    else                                         code = code_hidden;
    case (code)
      4'h0:    rgb = rgb_code_0;
      4'h1:    rgb = rgb_code_1;
      4'h2:    rgb = rgb_code_2;
      4'h3:    rgb = rgb_code_3;
      4'h4:    rgb = rgb_code_4;
      4'h5:    rgb = rgb_code_5;
      4'h6:    rgb = rgb_code_6;
      4'h7:    rgb = rgb_code_7;
      4'h8:    rgb = rgb_code_8;
      4'h9:    rgb = rgb_code_9;
      4'hA:    rgb = rgb_code_10;
      4'hC:    rgb = rgb_code_12;
      default: rgb = 24'h000000;
    endcase
    return {code, rgb};
  endfunction

  task automatic model_step(input cmd_t op, input logic [63:0] map);
    int idx;
    idx = int'(cur_r) * 8 + int'(cur_c);
    if (op == CMD_LOAD) begin
      mine_m  = map;
      rev_m   = '0;
      flag_m  = '0;
      cur_r   = '0;
      cur_c   = '0;
      state_m = GAME_PLAY;
    end else if (state_m == GAME_PLAY) begin
      case (op)
        CMD_UP:    cur_r = cur_r - 3'd1;
        CMD_DOWN:  cur_r = cur_r + 3'd1;
        CMD_LEFT:  cur_c = cur_c - 3'd1;
        CMD_RIGHT: cur_c = cur_c + 3'd1;
        CMD_REVEAL: begin
          if (!flag_m[idx] && !rev_m[idx]) begin
            rev_m[idx] = 1'b1;
            if (mine_m[idx])                 state_m = GAME_LOST;
            else if ((rev_m | mine_m) == '1) state_m = GAME_WON;  // no safe cell left
          end
        end
        CMD_FLAG: begin
          if (!rev_m[idx]) flag_m[idx] = ~flag_m[idx];
        end
        default: begin
        end
      endcase
    end
  endtask

  task automatic read_cell(input int r, input int c);
    logic [27:0] e;
    e         = expected_cell(r, c);
    rd_en     = 1'b1;
    rd_row    = 3'(r);
    rd_col    = 3'(c);
    exp_code  = e[27:24];
    exp_rgb   = e[23:0];
    exp_state = state_m;
    exp_row   = cur_r;
    exp_col   = cur_c;
    @(negedge clk);
  endtask

  task automatic sweep_board();
    for (int r = 0; r < 8; r++) begin
      for (int c = 0; c < 8; c++) read_cell(r, c);     // back to back
    end
    rd_en = 1'b0;
    @(negedge clk);
  endtask

  task automatic run_cmd(input cmd_t op, input logic [63:0] map);
    cmd_valid = 1'b1;
    cmd       = op;
    mine_map  = map;
    model_step(op, map);
    @(negedge clk);
    cmd_valid = 1'b0;
    cmd       = CMD_NOP;
    sweep_board();
  endtask

  // serpentine walk that opens every safe cell but skip_idx
  task automatic walk_board(input int skip_idx);
    int c;
    int idx;
    for (int r = 0; r < 8; r++) begin
      for (int k = 0; k < 8; k++) begin
        c   = (r % 2 == 0) ? k : 7 - k;
        idx = r * 8 + c;
        if (!mine_m[idx] && idx != skip_idx) run_cmd(CMD_REVEAL, '0);
        if (k < 7) begin
          if (r % 2 == 0) run_cmd(CMD_RIGHT, '0);
          else            run_cmd(CMD_LEFT, '0);
        end else if (r < 7) begin
          run_cmd(CMD_DOWN, '0);
        end
      end
    end
  endtask

  task automatic finish_test();
    test_done = 1'b1;
    @(negedge clk);
    test_done = 1'b0;
    test_id++;
  endtask

  initial begin
    logic [63:0] map;
    logic [63:0] pick;
    cmd_t        op;
    clk        = 1'b0;
    rst        = 1'b1;
    cmd_valid  = 1'b0;
    cmd        = CMD_NOP;
    mine_map   = '0;
    rd_en      = 1'b0;
    rd_row     = '0;
    rd_col     = '0;
    exp_code   = '0;
    exp_rgb    = '0;
    exp_state  = GAME_IDLE;
    exp_row    = '0;
    exp_col    = '0;
    test_id    = 0;
    test_done  = 1'b0;
    all_done   = 1'b0;
    mine_m     = '0;
    rev_m      = '0;
    flag_m     = '0;
    cur_r      = '0;
    cur_c      = '0;
    state_m    = GAME_IDLE;
    lfsr_state = 32'h2d040275;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    sweep_board();                                        // idle board after reset
    finish_test();

    random_map(map);
    map = map & ~64'h8100_0000_0800_0081;                 // safe corners and cell 3,3
    run_cmd(CMD_LOAD, map);
    walk_board(27);                                       // 3,3 stays shut so there is no win
    finish_test();

    random_map(map);
    map[0] = 1'b1;                                        // flagged mine at 0,0
    run_cmd(CMD_LOAD, map);
    run_cmd(CMD_UP, '0);                                  // top edge wraps to row 7
    run_cmd(CMD_DOWN, '0);
    run_cmd(CMD_LEFT, '0);                                // left edge wraps to col 7
    run_cmd(CMD_RIGHT, '0);
    run_cmd(CMD_FLAG, '0);
    run_cmd(CMD_REVEAL, '0);                              // refused on a flag
    run_cmd(CMD_FLAG, '0);
    run_cmd(CMD_FLAG, '0);
    run_cmd(CMD_RIGHT, '0);
    for (int i = 0; i < 4; i++) begin
      rand_bits(2, pick);
      case (pick[1:0])
        2'd0:    op = CMD_UP;
        2'd1:    op = CMD_DOWN;
        2'd2:    op = CMD_LEFT;
        default: op = CMD_RIGHT;
      endcase
      run_cmd(op, '0);
    end
    finish_test();

    random_map(map);
    map[0] = 1'b1;
    run_cmd(CMD_LOAD, map);
    run_cmd(CMD_REVEAL, '0);                              // step on the mine
    run_cmd(CMD_RIGHT, '0);
    run_cmd(CMD_REVEAL, '0);
    run_cmd(CMD_FLAG, '0);
    finish_test();

    rand_bits(12, pick);
    map = '0;
    map[pick[5:0]]  = 1'b1;                               // one or two mines
    map[pick[11:6]] = 1'b1;
    run_cmd(CMD_LOAD, map);
    walk_board(-1);
    run_cmd(CMD_LOAD, map);                               // back to play with a cleared board
    finish_test();

    for (int i = 0; i < 8; i++) begin
      read_cell(i, i);                                    // reads with a gap between
      rd_en = 1'b0;
      @(negedge clk);
    end
    finish_test();

    all_done = 1'b1;
    @(negedge clk);
    all_done = 1'b0;
    @(negedge clk);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
